// ==== project.f ====
+incdir+.
vec_pkg.sv
vec_decoder.sv
vec_alu.sv
vec_regfile.sv
vec_controller.sv
vec_unit.sv
tb_vec_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_vec_unit -o sim_vec_unit

./obj_dir/sim_vec_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi

// ==== tb_vec_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Vector coprocessor testbench
// Table of Wishbone transfers checked against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module tb_vec_unit import vec_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int KIND_WR      = 0;
	localparam int KIND_RD      = 1;
	localparam int KIND_INSTR   = 2;
	localparam int FORM_VV      = 0;
	localparam int FORM_VX      = 1;
	localparam int FORM_VI      = 2;

	localparam logic [6:0]  OPC_VEC     = 7'b1010111;
	localparam logic [10:0] VTYPE_E32   = 11'h010;
	localparam logic [10:0] VTYPE_E8    = 11'h000;
	localparam logic [9:0]  VTYPE_E32_I = 10'h010;

	typedef struct {
		int          kind;
		string       name;
		logic [11:0] addr;
		logic [31:0] data;
		logic        exp_err;
		logic [31:0] exp_rd;
	} entry_t;

	logic        clk;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [11:0] adr;
	logic [31:0] dat;
	logic [31:0] dat_o;
	logic        ack_o;
	logic        err_o;

	entry_t      table_q[$];
	bit          table_built;
	int          errors;
	int          checks;
	logic [31:0] lfsr_q;

	// Reference state
	logic [31:0] model [`VEC_NREGS][`VEC_VLMAX];
	logic [31:0] model_vl;
	logic [31:0] model_rd;
	logic [31:0] model_rs1;

	vec_unit vec_unit_inst (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.cyc_i   (cyc),
		.stb_i   (stb),
		.we_i    (we),
		.adr_i   (adr),
		.dat_i   (dat),
		.dat_o   (dat_o),
		.ack_o   (ack_o),
		.err_o   (err_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Random data and instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			w = {w[30:0], lfsr_q[0]};
		end
		return w;
	endfunction

	function automatic logic [11:0] elem_addr(input int r, input int e);
		return `VEC_ADDR_VREG + 12'(r * 32 + e * 4);
	endfunction

	function automatic logic [31:0] enc_arith(input logic [5:0] f6, input logic vm,
			input logic [4:0] vs2, input logic [4:0] src1, input logic [2:0] f3,
			input logic [4:0] vd);
		return {f6, vm, vs2, src1, f3, vd, OPC_VEC};
	endfunction

	function automatic logic [31:0] enc_vsetvli(input logic [10:0] vtype, input logic [4:0] rs1,
			input logic [4:0] rd);
		return {1'b0, vtype, rs1, 3'b111, rd, OPC_VEC};
	endfunction

	function automatic logic [31:0] enc_vsetivli(input logic [9:0] vtype, input logic [4:0] uimm,
			input logic [4:0] rd);
		return {2'b11, vtype, uimm, 3'b111, rd, OPC_VEC};
	endfunction

	// funct6 and legal forms as {vi, vx, vv}
	function automatic void op_info(input vec_op_e op, output logic [5:0] f6,
			output logic [2:0] forms);
		case (op)
			VOP_ADD:  begin f6 = 6'b000000; forms = 3'b111; end
			VOP_SUB:  begin f6 = 6'b000010; forms = 3'b011; end
			VOP_RSUB: begin f6 = 6'b000011; forms = 3'b110; end
			VOP_MINU: begin f6 = 6'b000100; forms = 3'b011; end
			VOP_MIN:  begin f6 = 6'b000101; forms = 3'b011; end
			VOP_MAXU: begin f6 = 6'b000110; forms = 3'b011; end
			VOP_MAX:  begin f6 = 6'b000111; forms = 3'b011; end
			VOP_AND:  begin f6 = 6'b001001; forms = 3'b111; end
			VOP_OR:   begin f6 = 6'b001010; forms = 3'b111; end
			VOP_XOR:  begin f6 = 6'b001011; forms = 3'b111; end
			VOP_MV:   begin f6 = 6'b010111; forms = 3'b111; end
			VOP_SLL:  begin f6 = 6'b100101; forms = 3'b111; end
			VOP_SRL:  begin f6 = 6'b101000; forms = 3'b111; end
			VOP_SRA:  begin f6 = 6'b101001; forms = 3'b111; end
			default:  begin f6 = 6'b111111; forms = 3'b000; end
		endcase
	endfunction

	// Expected element with a from vs2 and b the second operand
	function automatic logic [31:0] ref_elem(input vec_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		int         sa;
		int         sb;
		logic [4:0] sh;
		sa = a;
		sb = b;
		sh = b[4:0];
		case (op)
			VOP_ADD:  return a + b;
			VOP_SUB:  return a - b;
			VOP_RSUB: return b - a;
			VOP_AND:  return a & b;
			VOP_OR:   return a | b;
			VOP_XOR:  return a ^ b;
			VOP_SLL:  return a << sh;
			VOP_SRL:  return a >> sh;
			VOP_SRA:  return 32'(sa >>> sh);
			VOP_MIN:  return (sa < sb) ? a : b;
			VOP_MINU: return (a < b) ? a : b;
			VOP_MAX:  return (sa > sb) ? a : b;
			VOP_MAXU: return (a > b) ? a : b;
			VOP_MV:   return b;
			default:  return '0;
		endcase
	endfunction

	function automatic string resp_name(input logic [1:0] resp);
		case (resp)
			2'b01:   return "ack";
			2'b10:   return "err";
			2'b11:   return "ack and err";
			default: return "neither";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Table construction with the model tracking each entry
	//////////////////////////////////////////////////////////////////////

	task automatic add_entry(input int kind, input string name, input logic [11:0] addr,
			input logic [31:0] data, input logic exp_err, input logic [31:0] exp_rd);
		entry_t ent;
		ent.kind    = kind;
		ent.name    = name;
		ent.addr    = addr;
		ent.data    = data;
		ent.exp_err = exp_err;
		ent.exp_rd  = exp_rd;
		table_q.push_back(ent);
	endtask

	task automatic add_write(input string name, input logic [11:0] addr, input logic [31:0] data);
		add_entry(KIND_WR, name, addr, data, 1'b0, '0);
		if (addr == `VEC_ADDR_RS1) begin
			model_rs1 = data;
		end else if (addr >= `VEC_ADDR_VREG) begin
			model[int'(addr[7:5])][int'(addr[4:2])] = data;
		end
	endtask

	task automatic add_read(input string name, input logic [11:0] addr, input logic [31:0] exp);
		add_entry(KIND_RD, name, addr, '0, 1'b0, exp);
	endtask

	task automatic add_instr(input string name, input logic [31:0] word, input logic exp_err);
		add_entry(KIND_INSTR, name, `VEC_ADDR_INSTR, word, exp_err, '0);
	endtask

	task automatic fill_vreg(input int r);
		for (int e = 0; e < `VEC_VLMAX; e++) begin
			add_write($sformatf("wr_v%0d[%0d]", r, e), elem_addr(r, e), rand_bits(32));
		end
	endtask

	task automatic check_vreg(input string tag, input int r);
		for (int e = 0; e < `VEC_VLMAX; e++) begin
			add_read($sformatf("%s_v%0d[%0d]", tag, r, e), elem_addr(r, e), model[r][e]);
		end
	endtask

	// vl is the request capped at VLMAX and rd x0 drops the rd write
	task automatic add_vset(input string name, input logic [31:0] word, input logic [31:0] req,
			input logic keep, input int rd);
		add_instr(name, word, 1'b0);
		if (!keep) begin
			model_vl = (req > 32'(`VEC_VLMAX)) ? 32'(`VEC_VLMAX) : req;
		end
		if (rd != 0) begin
			model_rd = model_vl;
		end
		add_read({name, "_vl"}, `VEC_ADDR_STATUS, model_vl);
		add_read({name, "_rd"}, `VEC_ADDR_RD, model_rd);
	endtask

	task automatic add_op(input vec_op_e op, input int form, input int vd, input int vs2,
			input int vs1);
		logic [5:0]  f6;
		logic [2:0]  forms;
		logic [2:0]  f3;
		logic [4:0]  src1;
		logic [4:0]  imm;
		logic [31:0] b;
		int          va;
		string       name;
		op_info(op, f6, forms);
		// vmv.v has a zero vs2 field
		va = (op == VOP_MV) ? 0 : vs2;
		imm = 5'(rand_bits(5));
		if (form == FORM_VV) begin
			f3 = 3'b000;
			src1 = 5'(vs1);
			name = $sformatf("%s.vv", op.name());
		end else if (form == FORM_VX) begin
			f3 = 3'b100;
			src1 = 5'd12;
			name = $sformatf("%s.vx", op.name());
			add_write({name, "_rs1"}, `VEC_ADDR_RS1, rand_bits(32));
		end else begin
			f3 = 3'b011;
			src1 = imm;
			name = $sformatf("%s.vi", op.name());
		end
		for (int e = 0; e < int'(model_vl); e++) begin
			if (form == FORM_VV) begin
				b = model[vs1][e];
			end else if (form == FORM_VX) begin
				b = model_rs1;
			end else begin
				b = {{27{imm[4]}}, imm};
			end
			model[vd][e] = ref_elem(op, model[va][e], b);
		end
		add_instr(name, enc_arith(f6, 1'b1, 5'(va), src1, f3, 5'(vd)), 1'b0);
		check_vreg(name, vd);
	endtask

	task automatic build_table();
		logic [5:0] f6;
		logic [2:0] forms;
		lfsr_q    = 32'd69;
		model_vl  = '0;
		model_rd  = '0;
		model_rs1 = '0;
		for (int r = 0; r < `VEC_NREGS; r++) begin
			for (int e = 0; e < `VEC_VLMAX; e++) begin
				model[r][e] = '0;
			end
		end

		// Reset state and element window
		add_read("status_reset", `VEC_ADDR_STATUS, '0);
		add_read("rd_reset", `VEC_ADDR_RD, '0);
		fill_vreg(1);
		fill_vreg(2);
		fill_vreg(3);
		fill_vreg(7);
		check_vreg("window", 1);
		check_vreg("window", 2);
		check_vreg("window", 3);
		check_vreg("window", 7);

		// Vector length setting
		add_write("rs1_3", `VEC_ADDR_RS1, 32'd3);
		add_vset("vsetvli_3", enc_vsetvli(VTYPE_E32, 5'd10, 5'd5), 32'd3, 1'b0, 5);
		add_write("rs1_8", `VEC_ADDR_RS1, 32'd8);
		add_vset("vsetvli_8", enc_vsetvli(VTYPE_E32, 5'd10, 5'd5), 32'd8, 1'b0, 5);
		add_write("rs1_20", `VEC_ADDR_RS1, 32'd20);
		add_vset("vsetvli_20", enc_vsetvli(VTYPE_E32, 5'd11, 5'd6), 32'd20, 1'b0, 6);
		add_vset("vsetivli_5", enc_vsetivli(VTYPE_E32_I, 5'd5, 5'd7), 32'd5, 1'b0, 7);
		add_vset("vsetvli_keep", enc_vsetvli(VTYPE_E32, 5'd0, 5'd0), '0, 1'b1, 0);
		add_vset("vsetvli_x0", enc_vsetvli(VTYPE_E32, 5'd0, 5'd5), '1, 1'b0, 5);

		// Every operation and form at vl 8
		for (int k = 0; k <= int'(VOP_MV); k++) begin
			op_info(vec_op_e'(k), f6, forms);
			for (int f = 0; f < 3; f++) begin
				if (forms[f]) begin
					add_op(vec_op_e'(k), f, 4, 1, 2);
				end
			end
		end

		// Tail elements stay put at vl 3
		add_vset("vsetivli_3", enc_vsetivli(VTYPE_E32_I, 5'd3, 5'd7), 32'd3, 1'b0, 7);
		add_op(VOP_XOR, FORM_VX, 3, 1, 2);
		add_op(VOP_ADD, FORM_VV, 5, 2, 3);

		// Illegal encodings
		add_instr("masked_vadd", enc_arith(6'b000000, 1'b0, 5'd1, 5'd2, 3'b000, 5'd4), 1'b1);
		add_instr("vmul_vv", enc_arith(6'b100101, 1'b1, 5'd1, 5'd2, 3'b010, 5'd4), 1'b1);
		add_instr("vfadd_vv", enc_arith(6'b000000, 1'b1, 5'd1, 5'd2, 3'b001, 5'd4), 1'b1);
		add_instr("vadd_vd9", enc_arith(6'b000000, 1'b1, 5'd1, 5'd2, 3'b000, 5'd9), 1'b1);
		add_instr("scalar_addi", 32'h00000013, 1'b1);
		add_write("rs1_2", `VEC_ADDR_RS1, 32'd2);
		add_instr("vset_sew8", enc_vsetvli(VTYPE_E8, 5'd10, 5'd5), 1'b1);
		add_read("illegal_vl", `VEC_ADDR_STATUS, model_vl);
		add_read("illegal_rd", `VEC_ADDR_RD, model_rd);
		for (int r = 0; r < `VEC_NREGS; r++) begin
			check_vreg("final", r);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus driver and main sequence
	//////////////////////////////////////////////////////////////////////

	task automatic bus_xfer(input logic write, input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] got_resp, output logic [31:0] got_rd);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= write;
		adr <= addr;
		dat <= data;
		@(posedge clk);
		while (!(ack_o || err_o)) begin
			@(posedge clk);
		end
		got_resp = {err_o, ack_o};
		got_rd   = dat_o;
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	initial begin
		entry_t      ent;
		logic [1:0]  got_resp;
		logic [1:0]  exp_resp;
		logic [31:0] got_rd;
		clk    = 1'b0;
		rst_n  = 1'b0;
		cyc    = 1'b0;
		stb    = 1'b0;
		we     = 1'b0;
		adr    = '0;
		dat    = '0;
		errors = 0;
		checks = 0;
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		foreach (table_q[i]) begin
			ent = table_q[i];
			bus_xfer(ent.kind != KIND_RD, ent.addr, ent.data, got_resp, got_rd);
			exp_resp = ent.exp_err ? 2'b10 : 2'b01;
			checks++;
			assert (got_resp === exp_resp) else begin
				errors++;
				$display("ERROR %s: expected %s, actual %s", ent.name,
					resp_name(exp_resp), resp_name(got_resp));
			end
			if (ent.kind == KIND_RD) begin
				checks++;
				assert (got_rd === ent.exp_rd) else begin
					errors++;
					$display("ERROR %s: expected 0x%08h, actual 0x%08h", ent.name,
						ent.exp_rd, got_rd);
				end
			end
		end

		$display("Transfers: %0d, checks: %0d, errors: %0d", table_q.size(), checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog allows 20 cycles per table entry
	initial begin
		wait (table_built);
		#((table_q.size() * 20 + RESET_CYCLES) * CLK_PERIOD);
		$display("Timeout: the bus transfers did not finish in the expected time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule : tb_vec_unit

// ==== vec_alu.sv ====
//////////////////////////////////////////////////////////////////////
// Vector element ALU
// One 32-bit integer element per cycle, a is vs2 and b the other operand
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_alu import vec_pkg::*; (
	input  vec_op_e              op_i,
	input  logic [`VEC_ELEN-1:0] a_i,
	input  logic [`VEC_ELEN-1:0] b_i,
	output logic [`VEC_ELEN-1:0] res_o
);

	localparam int SH_W = $clog2(`VEC_ELEN);

	logic [SH_W-1:0] shamt;
	logic            lt_s;
	logic            lt_u;

	// Only the low bits of b select the shift
	assign shamt = b_i[SH_W-1:0];
	assign lt_s  = $signed(a_i) < $signed(b_i);
	assign lt_u  = a_i < b_i;

	always_comb begin
		case (op_i)
			VOP_ADD:  res_o = a_i + b_i;
			VOP_SUB:  res_o = a_i - b_i;
			VOP_RSUB: res_o = b_i - a_i;
			VOP_AND:  res_o = a_i & b_i;
			VOP_OR:   res_o = a_i | b_i;
			VOP_XOR:  res_o = a_i ^ b_i;
			VOP_SLL:  res_o = a_i << shamt;
			VOP_SRL:  res_o = a_i >> shamt;
			VOP_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
			VOP_MIN:  res_o = lt_s ? a_i : b_i;
			VOP_MINU: res_o = lt_u ? a_i : b_i;
			VOP_MAX:  res_o = lt_s ? b_i : a_i;
			VOP_MAXU: res_o = lt_u ? b_i : a_i;
			VOP_MV:   res_o = b_i;
			default:  res_o = '0;
		endcase
	end

endmodule : vec_alu

// ==== vec_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Vector coprocessor constants
// Register file sizes and the Wishbone byte address map
//////////////////////////////////////////////////////////////////////

`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// Register file geometry, SEW fixed at 32 and LMUL at 1
`define VEC_NREGS 8
`define VEC_VLMAX 8
`define VEC_ELEN 32

//////////////////////////////////////////////////////////////////////
// Host address map, 12-bit byte addresses
//////////////////////////////////////////////////////////////////////

`define VEC_ADDR_RS1 12'h000
`define VEC_ADDR_INSTR 12'h004
`define VEC_ADDR_STATUS 12'h008
`define VEC_ADDR_RD 12'h00C
// Element window, offset is reg * 32 + element * 4
`define VEC_ADDR_VREG 12'h100

`endif

// ==== vec_controller.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit controller
// Wishbone slave, vl and rd state, and the element sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_controller import vec_pkg::*; #(
	parameter int VL_W = $clog2(`VEC_VLMAX + 1),
	parameter int EL_W = $clog2(`VEC_VLMAX),
	parameter int RI_W = $clog2(`VEC_NREGS)
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Wishbone slave
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  logic [11:0]          adr_i,
	input  logic [31:0]          dat_i,
	output logic [31:0]          dat_o,
	output logic                 ack_o,
	output logic                 err_o,
	// Decoder
	output logic                 instr_valid_o,
	output logic [`VEC_ELEN-1:0] rs1_o,
	input  logic                 dec_illegal_i,
	input  logic                 dec_valid_i,
	input  vec_op_e              dec_op_i,
	input  vec_src_e             dec_src_i,
	input  logic [4:0]           dec_vd_i,
	input  logic [4:0]           dec_vs1_i,
	input  logic [4:0]           dec_vs2_i,
	input  logic [31:0]          dec_imm_i,
	input  logic [4:0]           dec_cfg_rd_i,
	input  logic [31:0]          dec_cfg_avl_i,
	input  logic                 dec_keep_vl_i,
	// Register file
	output logic [RI_W-1:0]      rf_ra_a_o,
	output logic [RI_W-1:0]      rf_ra_b_o,
	output logic [EL_W-1:0]      rf_el_o,
	input  logic [`VEC_ELEN-1:0] rf_rd_a_i,
	input  logic [`VEC_ELEN-1:0] rf_rd_b_i,
	output logic                 rf_we_o,
	output logic [RI_W-1:0]      rf_wa_o,
	output logic [EL_W-1:0]      rf_wel_o,
	output logic [`VEC_ELEN-1:0] rf_wd_o,
	// ALU
	output vec_op_e              alu_op_o,
	output logic [`VEC_ELEN-1:0] alu_a_o,
	output logic [`VEC_ELEN-1:0] alu_b_o,
	input  logic [`VEC_ELEN-1:0] alu_res_i
);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_RESP} state_e;

	state_e               state_q;
	logic [EL_W-1:0]      el_q;
	logic [VL_W-1:0]      vl_q;
	logic [VL_W-1:0]      cfg_vl;
	logic [`VEC_ELEN-1:0] rs1_q;
	logic [`VEC_ELEN-1:0] rd_val_q;
	logic [`VEC_ELEN-1:0] rdata;
	vec_op_e              op_q;
	vec_src_e             src_q;
	logic [RI_W-1:0]      vd_q;
	logic [RI_W-1:0]      vs1_q;
	logic [RI_W-1:0]      vs2_q;
	logic [`VEC_ELEN-1:0] imm_q;
	logic                 start;
	logic                 hit_win;
	logic                 addr_ok;
	logic                 running;
	logic                 last_el;

	assign start   = (state_q == S_IDLE) && cyc_i && stb_i;
	assign hit_win = (adr_i & 12'hF00) == `VEC_ADDR_VREG;
	assign addr_ok = hit_win || (adr_i inside {`VEC_ADDR_RS1, `VEC_ADDR_INSTR,
		`VEC_ADDR_STATUS, `VEC_ADDR_RD});
	assign running = (state_q == S_RUN);
	assign last_el = (VL_W'(el_q) == vl_q - VL_W'(1));

	assign instr_valid_o = start && we_i && (adr_i == `VEC_ADDR_INSTR);
	assign rs1_o         = rs1_q;

	// New vl, capped at VLMAX
	always_comb begin
		if (dec_keep_vl_i) begin
			cfg_vl = vl_q;
		end else if (dec_cfg_avl_i > `VEC_VLMAX) begin
			cfg_vl = VL_W'(`VEC_VLMAX);
		end else begin
			cfg_vl = dec_cfg_avl_i[VL_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register file and ALU ports, host window when idle
	//////////////////////////////////////////////////////////////////////

	assign rf_ra_a_o = running ? vs2_q : adr_i[7:5];
	assign rf_ra_b_o = vs1_q;
	assign rf_el_o   = running ? el_q : adr_i[4:2];
	assign rf_we_o   = running || (start && we_i && hit_win);
	assign rf_wa_o   = running ? vd_q : adr_i[7:5];
	assign rf_wel_o  = running ? el_q : adr_i[4:2];
	assign rf_wd_o   = running ? alu_res_i : dat_i;

	assign alu_op_o = op_q;
	assign alu_a_o  = rf_rd_a_i;

	always_comb begin
		case (src_q)
			SRC_XS:  alu_b_o = rs1_q;
			SRC_IMM: alu_b_o = imm_q;
			default: alu_b_o = rf_rd_b_i;
		endcase
	end

	always_comb begin
		rdata = '0;
		if (hit_win) begin
			rdata = rf_rd_a_i;
		end else if (adr_i == `VEC_ADDR_RS1) begin
			rdata = rs1_q;
		end else if (adr_i == `VEC_ADDR_STATUS) begin
			rdata[VL_W-1:0] = vl_q;
		end else if (adr_i == `VEC_ADDR_RD) begin
			rdata = rd_val_q;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= S_IDLE;
			el_q     <= '0;
			vl_q     <= '0;
			rs1_q    <= '0;
			rd_val_q <= '0;
			ack_o    <= 1'b0;
			err_o    <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (instr_valid_o) begin
						state_q <= S_RESP;
						if (dec_illegal_i) begin
							err_o <= 1'b1;
						end else if (dec_valid_i && dec_op_i == VOP_CFG) begin
							vl_q  <= cfg_vl;
							ack_o <= 1'b1;
							// Writes to x0 are dropped
							if (dec_cfg_rd_i != 5'd0) begin
								rd_val_q <= {{(`VEC_ELEN - VL_W){1'b0}}, cfg_vl};
							end
						end else if (vl_q == '0) begin
							ack_o <= 1'b1;
						end else begin
							el_q    <= '0;
							state_q <= S_RUN;
						end
					end else if (start) begin
						state_q <= S_RESP;
						if (!addr_ok) begin
							err_o <= 1'b1;
						end else begin
							ack_o <= 1'b1;
							if (we_i && adr_i == `VEC_ADDR_RS1) begin
								rs1_q <= dat_i;
							end
						end
					end
				end
				S_RUN: begin
					if (last_el) begin
						ack_o   <= 1'b1;
						state_q <= S_RESP;
					end else begin
						el_q <= el_q + 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Decoded fields and read data
	always_ff @(posedge clk_i) begin
		if (instr_valid_o && dec_valid_i) begin
			op_q  <= dec_op_i;
			src_q <= dec_src_i;
			vd_q  <= dec_vd_i[RI_W-1:0];
			vs1_q <= dec_vs1_i[RI_W-1:0];
			vs2_q <= dec_vs2_i[RI_W-1:0];
			imm_q <= dec_imm_i;
		end
		if (start && !we_i) begin
			dat_o <= rdata;
		end
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) !(ack_o && err_o))
	else $error("ack and err raised together");

	assert property (@(posedge clk_i) disable iff (!rst_n_i) running |-> (VL_W'(el_q) < vl_q))
	else $error("element counter ran past vl");

endmodule : vec_controller

// ==== vec_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Vector instruction decoder
// Classifies an RVV instruction word into config or integer element op
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_decoder import vec_pkg::*; (
	input  logic        instr_valid_i,
	input  logic [31:0] instr_i,
	input  logic [31:0] rs1_i,
	output logic        illegal_o,
	output logic        valid_o,
	output vec_op_e     op_o,
	output vec_src_e    src_o,
	output logic [4:0]  vd_o,
	output logic [4:0]  vs1_o,
	output logic [4:0]  vs2_o,
	output logic [31:0] imm_o,
	output logic [4:0]  cfg_rd_o,
	output logic [31:0] cfg_avl_o,
	output logic        keep_vl_o
);

	localparam logic [6:0] OPC_VEC = 7'b1010111;
	localparam logic [2:0] F3_IVV  = 3'b000;
	localparam logic [2:0] F3_IVI  = 3'b011;
	localparam logic [2:0] F3_IVX  = 3'b100;
	localparam logic [2:0] F3_CFG  = 3'b111;
	localparam logic [2:0] VSEW_32 = 3'b010;

	logic [5:0] funct6;
	logic [2:0] funct3;
	logic [4:0] fld_rs1;
	logic       vtype_bad;
	// Legal forms of the matched funct6 as {vi, vx, vv}
	logic [2:0] forms;
	logic       bad;

	assign funct6   = instr_i[31:26];
	assign funct3   = instr_i[14:12];
	assign fld_rs1  = instr_i[19:15];
	assign vd_o     = instr_i[11:7];
	assign vs1_o    = instr_i[19:15];
	assign vs2_o    = instr_i[24:20];
	assign cfg_rd_o = instr_i[11:7];
	assign imm_o    = {{27{instr_i[19]}}, instr_i[19:15]};

	// Only LMUL 1 and SEW 32 exist here
	assign vtype_bad = (instr_i[22:20] != 3'b000) || (instr_i[25:23] != VSEW_32);

	always_comb begin
		bad       = 1'b0;
		forms     = 3'b000;
		op_o      = VOP_ADD;
		src_o     = SRC_VS1;
		cfg_avl_o = rs1_i;
		keep_vl_o = 1'b0;

		if (instr_i[6:0] != OPC_VEC) begin
			bad = 1'b1;
		end else if (funct3 == F3_CFG) begin
			op_o = VOP_CFG;
			if (!instr_i[31]) begin
				bad = vtype_bad;
			end else if (instr_i[31:30] == 2'b11) begin
				// vsetivli carries the AVL as uimm
				bad       = vtype_bad;
				cfg_avl_o = {27'b0, fld_rs1};
			end else if (instr_i[31:25] != 7'b1000000) begin
				bad = 1'b1;
			end
			// The vtype of vsetvl sits in x[rs2] and is not checked
			if (instr_i[31:30] != 2'b11 && fld_rs1 == 5'd0) begin
				if (cfg_rd_o != 5'd0) begin
					cfg_avl_o = '1;
				end else begin
					keep_vl_o = 1'b1;
				end
			end
		end else begin
			case (funct3)
				F3_IVV: src_o = SRC_VS1;
				F3_IVX: src_o = SRC_XS;
				F3_IVI: src_o = SRC_IMM;
				default: bad = 1'b1;
			endcase

			case (funct6)
				6'b000000: begin op_o = VOP_ADD;  forms = 3'b111; end
				6'b000010: begin op_o = VOP_SUB;  forms = 3'b011; end
				6'b000011: begin op_o = VOP_RSUB; forms = 3'b110; end
				6'b000100: begin op_o = VOP_MINU; forms = 3'b011; end
				6'b000101: begin op_o = VOP_MIN;  forms = 3'b011; end
				6'b000110: begin op_o = VOP_MAXU; forms = 3'b011; end
				6'b000111: begin op_o = VOP_MAX;  forms = 3'b011; end
				6'b001001: begin op_o = VOP_AND;  forms = 3'b111; end
				6'b001010: begin op_o = VOP_OR;   forms = 3'b111; end
				6'b001011: begin op_o = VOP_XOR;  forms = 3'b111; end
				6'b010111: begin op_o = VOP_MV;   forms = 3'b111; end
				6'b100101: begin op_o = VOP_SLL;  forms = 3'b111; end
				6'b101000: begin op_o = VOP_SRL;  forms = 3'b111; end
				6'b101001: begin op_o = VOP_SRA;  forms = 3'b111; end
				default: bad = 1'b1;
			endcase

			if (!((funct3 == F3_IVV && forms[0]) || (funct3 == F3_IVX && forms[1]) ||
					(funct3 == F3_IVI && forms[2]))) begin
				bad = 1'b1;
			end
			// vm = 0 marks masked forms and vmerge
			if (!instr_i[25]) begin
				bad = 1'b1;
			end
			if (vd_o >= `VEC_NREGS || vs2_o >= `VEC_NREGS) begin
				bad = 1'b1;
			end
			if (src_o == SRC_VS1 && vs1_o >= `VEC_NREGS) begin
				bad = 1'b1;
			end
		end
	end

	assign illegal_o = instr_valid_i & bad;
	assign valid_o   = instr_valid_i & ~bad;

endmodule : vec_decoder

// ==== vec_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector coprocessor types
// Operation and operand-source encodings shared by the datapath
//////////////////////////////////////////////////////////////////////

package vec_pkg;

	// Element operation, VOP_CFG marks the vset family
	typedef enum logic [3:0] {
		VOP_ADD,
		VOP_SUB,
		VOP_RSUB,
		VOP_AND,
		VOP_OR,
		VOP_XOR,
		VOP_SLL,
		VOP_SRL,
		VOP_SRA,
		VOP_MIN,
		VOP_MINU,
		VOP_MAX,
		VOP_MAXU,
		VOP_MV,
		VOP_CFG
	} vec_op_e;

	// Where the second operand comes from
	typedef enum logic [1:0] {
		SRC_VS1,
		SRC_XS,
		SRC_IMM
	} vec_src_e;

endpackage : vec_pkg

// ==== vec_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// Vector register file
// 8 registers of 8 x 32-bit elements, two read ports, one write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_regfile #(
	parameter int RI_W = $clog2(`VEC_NREGS),
	parameter int EL_W = $clog2(`VEC_VLMAX)
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic [RI_W-1:0]      ra_a_i,
	input  logic [RI_W-1:0]      ra_b_i,
	input  logic [EL_W-1:0]      el_i,
	output logic [`VEC_ELEN-1:0] rd_a_o,
	output logic [`VEC_ELEN-1:0] rd_b_o,
	input  logic                 we_i,
	input  logic [RI_W-1:0]      wa_i,
	input  logic [EL_W-1:0]      wel_i,
	input  logic [`VEC_ELEN-1:0] wd_i
);

	logic [`VEC_ELEN-1:0] mem_q [`VEC_NREGS][`VEC_VLMAX];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int r = 0; r < `VEC_NREGS; r++) begin
				for (int e = 0; e < `VEC_VLMAX; e++) begin
					mem_q[r][e] <= '0;
				end
			end
		end else if (we_i) begin
			mem_q[wa_i][wel_i] <= wd_i;
		end
	end

	// Both ports read the same element
	assign rd_a_o = mem_q[ra_a_i][el_i];
	assign rd_b_o = mem_q[ra_b_i][el_i];

	assert property (@(posedge clk_i) disable iff (!rst_n_i) we_i |-> !$isunknown(wa_i))
	else $error("write with unknown register address");

endmodule : vec_regfile

// ==== vec_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Vector coprocessor top level
// Wishbone slave with decoder, controller, register file and ALU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_unit import vec_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [11:0] adr_i,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic        err_o
);

	localparam int EL_W = $clog2(`VEC_VLMAX);
	localparam int RI_W = $clog2(`VEC_NREGS);

	// Decoder results
	logic                 instr_valid;
	logic [`VEC_ELEN-1:0] rs1;
	logic                 dec_illegal;
	logic                 dec_valid;
	vec_op_e              dec_op;
	vec_src_e             dec_src;
	logic [4:0]           dec_vd;
	logic [4:0]           dec_vs1;
	logic [4:0]           dec_vs2;
	logic [31:0]          dec_imm;
	logic [4:0]           dec_cfg_rd;
	logic [31:0]          dec_cfg_avl;
	logic                 dec_keep_vl;

	// Register file and ALU
	logic [RI_W-1:0]      rf_ra_a;
	logic [RI_W-1:0]      rf_ra_b;
	logic [EL_W-1:0]      rf_el;
	logic [`VEC_ELEN-1:0] rf_rd_a;
	logic [`VEC_ELEN-1:0] rf_rd_b;
	logic                 rf_we;
	logic [RI_W-1:0]      rf_wa;
	logic [EL_W-1:0]      rf_wel;
	logic [`VEC_ELEN-1:0] rf_wd;
	vec_op_e              alu_op;
	logic [`VEC_ELEN-1:0] alu_a;
	logic [`VEC_ELEN-1:0] alu_b;
	logic [`VEC_ELEN-1:0] alu_res;

	vec_controller vec_controller_inst (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.cyc_i         (cyc_i),
		.stb_i         (stb_i),
		.we_i          (we_i),
		.adr_i         (adr_i),
		.dat_i         (dat_i),
		.dat_o         (dat_o),
		.ack_o         (ack_o),
		.err_o         (err_o),
		.instr_valid_o (instr_valid),
		.rs1_o         (rs1),
		.dec_illegal_i (dec_illegal),
		.dec_valid_i   (dec_valid),
		.dec_op_i      (dec_op),
		.dec_src_i     (dec_src),
		.dec_vd_i      (dec_vd),
		.dec_vs1_i     (dec_vs1),
		.dec_vs2_i     (dec_vs2),
		.dec_imm_i     (dec_imm),
		.dec_cfg_rd_i  (dec_cfg_rd),
		.dec_cfg_avl_i (dec_cfg_avl),
		.dec_keep_vl_i (dec_keep_vl),
		.rf_ra_a_o     (rf_ra_a),
		.rf_ra_b_o     (rf_ra_b),
		.rf_el_o       (rf_el),
		.rf_rd_a_i     (rf_rd_a),
		.rf_rd_b_i     (rf_rd_b),
		.rf_we_o       (rf_we),
		.rf_wa_o       (rf_wa),
		.rf_wel_o      (rf_wel),
		.rf_wd_o       (rf_wd),
		.alu_op_o      (alu_op),
		.alu_a_o       (alu_a),
		.alu_b_o       (alu_b),
		.alu_res_i     (alu_res)
	);

	// The bus data word is the instruction on an instruction write
	vec_decoder vec_decoder_inst (
		.instr_valid_i (instr_valid),
		.instr_i       (dat_i),
		.rs1_i         (rs1),
		.illegal_o     (dec_illegal),
		.valid_o       (dec_valid),
		.op_o          (dec_op),
		.src_o         (dec_src),
		.vd_o          (dec_vd),
		.vs1_o         (dec_vs1),
		.vs2_o         (dec_vs2),
		.imm_o         (dec_imm),
		.cfg_rd_o      (dec_cfg_rd),
		.cfg_avl_o     (dec_cfg_avl),
		.keep_vl_o     (dec_keep_vl)
	);

	vec_regfile vec_regfile_inst (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ra_a_i  (rf_ra_a),
		.ra_b_i  (rf_ra_b),
		.el_i    (rf_el),
		.rd_a_o  (rf_rd_a),
		.rd_b_o  (rf_rd_b),
		.we_i    (rf_we),
		.wa_i    (rf_wa),
		.wel_i   (rf_wel),
		.wd_i    (rf_wd)
	);

	vec_alu vec_alu_inst (
		.op_i  (alu_op),
		.a_i   (alu_a),
		.b_i   (alu_b),
		.res_o (alu_res)
	);

endmodule : vec_unit
